// File: verilog/pkt_buf_pkg.sv
`default_nettype none

package pkt_buf_pkg;

    // Full packet word as seen by writer and reader
    parameter int WORD_W = 64;
    // One memory port carries half a word
    parameter int HALF_W = WORD_W / 2;
    // Byte increment carried with every written word
    parameter int INC_W = 8;
    // Running byte length of one packet
    parameter int LEN_W = 32;

    // Word seen whole outside, or as two halves at the memory
    // Upper half lives at the even half-address, lower half at the odd one
    typedef union packed {
        logic [WORD_W-1:0] word;
        struct packed {
            logic [HALF_W-1:0] upper;
            logic [HALF_W-1:0] lower;
        } half;
    } word_u;

endpackage

`default_nettype wire

// File: verilog/dp_bram.sv
`default_nettype none

module dp_bram
    import pkt_buf_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
) (
    input  wire logic                  clk,
    input  wire logic                  en_i,
    input  wire logic [ADDR_WIDTH-1:0] addr_a_i,
    input  wire logic [ADDR_WIDTH-1:0] addr_b_i,
    input  wire logic                  wr_en_a_i,
    input  wire logic                  wr_en_b_i,
    input  wire logic [HALF_W-1:0]     din_a_i,
    input  wire logic [HALF_W-1:0]     din_b_i,
    output logic      [HALF_W-1:0]     dout_a_o,
    output logic      [HALF_W-1:0]     dout_b_o
);

    // Storage array, one entry per half-address
    logic [HALF_W-1:0] mem [2**ADDR_WIDTH];

    // Both ports share one clock and one enable
    // Read-first behaviour on each port
    always @(posedge clk) begin
        if (en_i) begin
            // Port A write
            if (wr_en_a_i) begin
                mem[addr_a_i] <= din_a_i;
            end
            // Port B write
            if (wr_en_b_i) begin
                mem[addr_b_i] <= din_b_i;
            end
            // Registered read data, one cycle latency
            dout_a_o <= mem[addr_a_i];
            dout_b_o <= mem[addr_b_i];
        end
    end

endmodule

`default_nettype wire

// File: verilog/pkt_buf.sv
`default_nettype none

module pkt_buf
    import pkt_buf_pkg::*;
#(
    parameter int ADDR_WIDTH = 10,
    parameter int BUF_IN     = 1,
    parameter int BUF_OUT    = 0
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  clr_i,
    input  wire logic                  rd_en_i,
    input  wire logic                  wr_en_i,
    input  wire logic [ADDR_WIDTH-2:0] idx_i,
    input  wire logic [WORD_W-1:0]     wdata_i,
    input  wire logic [INC_W-1:0]      byte_inc_i,
    output logic      [WORD_W-1:0]     rdata_o,
    output logic                       rvld_o,
    output logic      [LEN_W-1:0]      byte_len_o
);

    // Signals after the optional input stage
    logic                  rd_en_s;
    logic                  wr_en_s;
    logic [ADDR_WIDTH-2:0] idx_s;
    logic [WORD_W-1:0]     wdata_s;

    // Memory side
    logic [ADDR_WIDTH-1:0] addr_even;
    logic [ADDR_WIDTH-1:0] addr_odd;
    word_u                 wr_word;
    word_u                 rd_word;
    logic [HALF_W-1:0]     dout_even;
    logic [HALF_W-1:0]     dout_odd;
    logic                  vld_q;

    // Byte length counted from the undelayed strobe
    always_ff @(posedge clk) begin
        if (!rst || clr_i) begin
            byte_len_o <= '0;
        end else if (wr_en_i) begin
            byte_len_o <= byte_len_o + LEN_W'(byte_inc_i);
        end
    end

    // Optional input register stage
    if (BUF_IN != 0) begin : g_in
        logic                  rd_en_q;
        logic                  wr_en_q;
        logic [ADDR_WIDTH-2:0] idx_q;
        logic [WORD_W-1:0]     wdata_q;

        // Registered read and write strobes
        always_ff @(posedge clk) begin
            if (!rst) begin
                rd_en_q <= 1'b0;
                wr_en_q <= 1'b0;
            end else begin
                rd_en_q <= rd_en_i;
                wr_en_q <= wr_en_i;
            end
        end

        // Registered word index and write data
        always_ff @(posedge clk) begin
            idx_q   <= idx_i;
            wdata_q <= wdata_i;
        end

        assign rd_en_s = rd_en_q;
        assign wr_en_s = wr_en_q;
        assign idx_s   = idx_q;
        assign wdata_s = wdata_q;
    end else begin : g_no_in
        assign rd_en_s = rd_en_i;
        assign wr_en_s = wr_en_i;
        assign idx_s   = idx_i;
        assign wdata_s = wdata_i;
    end

    // Word index maps to a pair of half-addresses
    assign addr_even = {idx_s, 1'b0};
    assign addr_odd  = {idx_s, 1'b1};

    // Split the write word and rebuild the read word
    always_comb begin
        wr_word.word       = wdata_s;
        rd_word.half.upper = dout_even;
        rd_word.half.lower = dout_odd;
    end

    dp_bram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_mem (
        .clk       (clk),
        .en_i      (rd_en_s | wr_en_s),
        .addr_a_i  (addr_even),
        .addr_b_i  (addr_odd),
        .wr_en_a_i (wr_en_s),
        .wr_en_b_i (wr_en_s),
        .din_a_i   (wr_word.half.upper),
        .din_b_i   (wr_word.half.lower),
        .dout_a_o  (dout_even),
        .dout_b_o  (dout_odd)
    );

    // Valid follows the read strobe over the one-cycle memory read
    always_ff @(posedge clk) begin
        if (!rst) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= rd_en_s;
        end
    end

    // Optional output register stage
    if (BUF_OUT != 0) begin : g_out
        logic              rvld_q;
        logic [WORD_W-1:0] rdata_q;

        always_ff @(posedge clk) begin
            if (!rst) begin
                rvld_q <= 1'b0;
            end else begin
                rvld_q <= vld_q;
            end
        end

        always_ff @(posedge clk) begin
            rdata_q <= rd_word.word;
        end

        assign rvld_o  = rvld_q;
        assign rdata_o = rdata_q;
    end else begin : g_no_out
        assign rvld_o  = vld_q;
        assign rdata_o = rd_word.word;
    end

endmodule

`default_nettype wire

// File: verilog/buf_swap_ctrl.sv
`default_nettype none

module buf_swap_ctrl
    import pkt_buf_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Write side
    input  wire logic                  wr_en_i,
    input  wire logic [WORD_W-1:0]     wr_data_i,
    input  wire logic [INC_W-1:0]      byte_inc_i,
    input  wire logic                  wr_done_i,
    // Read side
    input  wire logic                  rd_en_i,
    input  wire logic [ADDR_WIDTH-2:0] rd_idx_i,
    input  wire logic                  rd_done_i,
    // Status and merged read result
    output logic                       wr_rdy_o,
    output logic                       pkt_rdy_o,
    output logic      [LEN_W-1:0]      pkt_len_o,
    output logic      [WORD_W-1:0]     rd_data_o,
    output logic                       rd_vld_o,
    // Bank A
    output logic                       rd_en_a_o,
    output logic                       wr_en_a_o,
    output logic                       clr_a_o,
    input  wire logic [WORD_W-1:0]     rdata_a_i,
    input  wire logic                  rvld_a_i,
    input  wire logic [LEN_W-1:0]      len_a_i,
    // Bank B
    output logic                       rd_en_b_o,
    output logic                       wr_en_b_o,
    output logic                       clr_b_o,
    input  wire logic [WORD_W-1:0]     rdata_b_i,
    input  wire logic                  rvld_b_i,
    input  wire logic [LEN_W-1:0]      len_b_i,
    // Shared to both banks
    output logic      [ADDR_WIDTH-2:0] wr_idx_o,
    output logic      [ADDR_WIDTH-2:0] rd_idx_o,
    output logic      [WORD_W-1:0]     wr_data_o,
    output logic      [INC_W-1:0]      byte_inc_o
);

    // Bank 0 is A, bank 1 is B
    logic                  fill_sel;
    logic                  drain_sel;
    logic [1:0]            full_q;
    logic [ADDR_WIDTH-2:0] wr_cnt_q;

    // Accepted strobes and pulses
    logic wr_acc;
    logic wr_done_acc;
    logic rd_acc;
    logic rd_done_acc;

    // Fill bank must be empty to take writes
    assign wr_rdy_o  = ~full_q[fill_sel];
    // Drain bank holds a finished packet
    assign pkt_rdy_o = full_q[drain_sel];

    assign wr_acc      = wr_en_i & wr_rdy_o;
    assign wr_done_acc = wr_done_i & wr_rdy_o;
    assign rd_acc      = rd_en_i & pkt_rdy_o;
    assign rd_done_acc = rd_done_i & pkt_rdy_o;

    // Bank selection and fullness
    always_ff @(posedge clk) begin
        if (!rst) begin
            fill_sel  <= 1'b0;
            drain_sel <= 1'b0;
            full_q    <= 2'b00;
        end else begin
            // Closing a packet hands the bank over to the reader
            if (wr_done_acc) begin
                full_q[fill_sel] <= 1'b1;
                fill_sel         <= ~fill_sel;
            end
            // Releasing frees the bank for a later fill
            // Never the same bank as a closing write in one cycle
            if (rd_done_acc) begin
                full_q[drain_sel] <= 1'b0;
                drain_sel         <= ~drain_sel;
            end
        end
    end

    // Write word index restarts with every packet
    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_cnt_q <= '0;
        end else if (wr_done_acc) begin
            wr_cnt_q <= '0;
        end else if (wr_acc) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
        end
    end

    // Steer strobes to the selected bank
    assign wr_en_a_o = wr_acc & ~fill_sel;
    assign wr_en_b_o = wr_acc & fill_sel;
    assign rd_en_a_o = rd_acc & ~drain_sel;
    assign rd_en_b_o = rd_acc & drain_sel;

    // Release clears the length of the drained bank
    assign clr_a_o = rd_done_acc & ~drain_sel;
    assign clr_b_o = rd_done_acc & drain_sel;

    // Data, increment and indices are common to both banks
    assign wr_idx_o   = wr_cnt_q;
    assign rd_idx_o   = rd_idx_i;
    assign wr_data_o  = wr_data_i;
    assign byte_inc_o = byte_inc_i;

    // Length of the packet waiting to drain
    assign pkt_len_o = drain_sel ? len_b_i : len_a_i;

    // Only one bank is read at a time so its valid picks the data
    assign rd_vld_o  = rvld_a_i | rvld_b_i;
    assign rd_data_o = rvld_b_i ? rdata_b_i : rdata_a_i;

endmodule

`default_nettype wire

// File: verilog/ping_pong_buf.sv
`default_nettype none

module ping_pong_buf
    import pkt_buf_pkg::*;
#(
    parameter int ADDR_WIDTH = 10,
    parameter int BUF_IN     = 1,
    parameter int BUF_OUT    = 0
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    // Writer
    input  wire logic                  wr_en_i,
    input  wire logic [WORD_W-1:0]     wr_data_i,
    input  wire logic [INC_W-1:0]      byte_inc_i,
    input  wire logic                  wr_done_i,
    // Reader
    input  wire logic                  rd_en_i,
    input  wire logic [ADDR_WIDTH-2:0] rd_idx_i,
    input  wire logic                  rd_done_i,
    // Status and read result
    output logic                       wr_rdy_o,
    output logic                       pkt_rdy_o,
    output logic      [LEN_W-1:0]      pkt_len_o,
    output logic      [WORD_W-1:0]     rd_data_o,
    output logic                       rd_vld_o
);

    // Per-bank strobes and results
    logic              rd_en_a;
    logic              wr_en_a;
    logic              clr_a;
    logic              rvld_a;
    logic              rd_en_b;
    logic              wr_en_b;
    logic              clr_b;
    logic              rvld_b;
    logic [WORD_W-1:0] rdata_a;
    logic [WORD_W-1:0] rdata_b;
    logic [LEN_W-1:0]  len_a;
    logic [LEN_W-1:0]  len_b;

    // Shared bank inputs
    logic [ADDR_WIDTH-2:0] wr_idx;
    logic [ADDR_WIDTH-2:0] rd_idx;
    logic [WORD_W-1:0]     wr_data;
    logic [INC_W-1:0]      byte_inc;

    // Bank A
    pkt_buf #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BUF_IN     (BUF_IN),
        .BUF_OUT    (BUF_OUT)
    ) u_buf_a (
        .clk        (clk),
        .rst        (rst),
        .clr_i      (clr_a),
        .rd_en_i    (rd_en_a),
        .wr_en_i    (wr_en_a),
        // A bank is either filling or draining, never both
        .idx_i      (wr_en_a ? wr_idx : rd_idx),
        .wdata_i    (wr_data),
        .byte_inc_i (byte_inc),
        .rdata_o    (rdata_a),
        .rvld_o     (rvld_a),
        .byte_len_o (len_a)
    );

    // Bank B
    pkt_buf #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BUF_IN     (BUF_IN),
        .BUF_OUT    (BUF_OUT)
    ) u_buf_b (
        .clk        (clk),
        .rst        (rst),
        .clr_i      (clr_b),
        .rd_en_i    (rd_en_b),
        .wr_en_i    (wr_en_b),
        .idx_i      (wr_en_b ? wr_idx : rd_idx),
        .wdata_i    (wr_data),
        .byte_inc_i (byte_inc),
        .rdata_o    (rdata_b),
        .rvld_o     (rvld_b),
        .byte_len_o (len_b)
    );

    buf_swap_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .wr_en_i    (wr_en_i),
        .wr_data_i  (wr_data_i),
        .byte_inc_i (byte_inc_i),
        .wr_done_i  (wr_done_i),
        .rd_en_i    (rd_en_i),
        .rd_idx_i   (rd_idx_i),
        .rd_done_i  (rd_done_i),
        .wr_rdy_o   (wr_rdy_o),
        .pkt_rdy_o  (pkt_rdy_o),
        .pkt_len_o  (pkt_len_o),
        .rd_data_o  (rd_data_o),
        .rd_vld_o   (rd_vld_o),
        .rd_en_a_o  (rd_en_a),
        .wr_en_a_o  (wr_en_a),
        .clr_a_o    (clr_a),
        .rdata_a_i  (rdata_a),
        .rvld_a_i   (rvld_a),
        .len_a_i    (len_a),
        .rd_en_b_o  (rd_en_b),
        .wr_en_b_o  (wr_en_b),
        .clr_b_o    (clr_b),
        .rdata_b_i  (rdata_b),
        .rvld_b_i   (rvld_b),
        .len_b_i    (len_b),
        .wr_idx_o   (wr_idx),
        .rd_idx_o   (rd_idx),
        .wr_data_o  (wr_data),
        .byte_inc_o (byte_inc)
    );

endmodule

`default_nettype wire

// File: dv/ping_pong_tb.sv
`default_nettype none

module ping_pong_tb
    import pkt_buf_pkg::*;
;

    localparam int ADDR_WIDTH = 6;
    localparam int IDX_W      = ADDR_WIDTH - 1;
    localparam int MAX_WORDS  = 2 ** IDX_W;
    localparam int CLK_PERIOD = 4;
    // Read latency with BUF_IN 1 and BUF_OUT 0
    localparam int RD_LAT     = 2;
    // Packets of up to MAX_WORDS words written over all tests
    localparam int NUM_PKTS   = 20;
    localparam int NUM_TESTS  = 6;
    localparam int CYC_PER_WORD = 8;
    localparam int WATCHDOG_TIME =
        (NUM_PKTS * MAX_WORDS + NUM_TESTS) * CYC_PER_WORD * CLK_PERIOD;

    logic              clk;
    logic              rst;
    logic              wr_en;
    logic [WORD_W-1:0] wr_data;
    logic [INC_W-1:0]  byte_inc;
    logic              wr_done;
    logic              rd_en;
    logic [IDX_W-1:0]  rd_idx;
    logic              rd_done;
    logic              wr_rdy;
    logic              pkt_rdy;
    logic [LEN_W-1:0]  pkt_len;
    logic [WORD_W-1:0] rd_data;
    logic              rd_vld;

    // Words, word counts and lengths of accepted packets
    logic [WORD_W-1:0] ref_words[$];
    int                ref_cnt[$];
    logic [LEN_W-1:0]  ref_len[$];
    // Number of banks holding a closed packet
    int                full_cnt;
    int                errors;

    ping_pong_buf #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .BUF_IN     (1),
        .BUF_OUT    (0)
    ) u_dut (
        .clk        (clk),
        .rst        (rst),
        .wr_en_i    (wr_en),
        .wr_data_i  (wr_data),
        .byte_inc_i (byte_inc),
        .wr_done_i  (wr_done),
        .rd_en_i    (rd_en),
        .rd_idx_i   (rd_idx),
        .rd_done_i  (rd_done),
        .wr_rdy_o   (wr_rdy),
        .pkt_rdy_o  (pkt_rdy),
        .pkt_len_o  (pkt_len),
        .rd_data_o  (rd_data),
        .rd_vld_o   (rd_vld)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp,
                         input string msg);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at time %0t: %s got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // Ready levels follow the bank count and length is known while a packet waits
    task automatic check_status(input string where);
        check(WORD_W'(wr_rdy), WORD_W'(full_cnt < 2), {where, ": wr_rdy_o"});
        check(WORD_W'(pkt_rdy), WORD_W'(full_cnt > 0), {where, ": pkt_rdy_o"});
        if (full_cnt > 0) begin
            check(WORD_W'(pkt_len), WORD_W'(ref_len[0]), {where, ": pkt_len_o"});
        end
    endtask

    // Front packet word index expected this cycle or -1 when none
    task automatic compare_read(input int exp_idx);
        if (exp_idx >= 0) begin
            if (!rd_vld) begin
                errors++;
                $display("rd_vld_o never arrived for word %0d at time %0t", exp_idx, $time);
            end else begin
                check(rd_data, ref_words[exp_idx], $sformatf("rd_data_o word %0d", exp_idx));
            end
        end else if (rd_vld) begin
            errors++;
            $display("rd_vld_o pulsed at time %0t with no read pending", $time);
        end
    endtask

    // Stream n random words and close the packet
    task automatic write_packet(input int n);
        logic [WORD_W-1:0] words[$];
        logic [LEN_W-1:0]  sum;
        logic [INC_W-1:0]  inc;
        logic              accept;
        sum = '0;
        @(negedge clk);
        // Dropped whole when both banks are full
        accept = (full_cnt < 2);
        check(WORD_W'(wr_rdy), WORD_W'(accept), "wr_rdy_o before packet");
        for (int i = 0; i < n; i++) begin
            inc      = INC_W'($urandom);
            wr_en    = 1'b1;
            wr_data  = {$urandom, $urandom};
            byte_inc = inc;
            words.push_back(wr_data);
            sum = sum + LEN_W'(inc);
            @(negedge clk);
        end
        wr_en   = 1'b0;
        wr_done = 1'b1;
        @(negedge clk);
        wr_done = 1'b0;
        if (accept) begin
            foreach (words[i]) begin
                ref_words.push_back(words[i]);
            end
            ref_cnt.push_back(n);
            ref_len.push_back(sum);
            full_cnt++;
        end
        check_status("after wr_done");
    endtask

    // Read every word of the front packet in shuffled order at one per cycle
    task automatic read_packet();
        int n;
        int j;
        int tmp;
        int exp_idx;
        int order[$];
        @(negedge clk);
        check(WORD_W'(pkt_rdy), WORD_W'(1'b1), "pkt_rdy_o before read");
        if (ref_cnt.size() == 0) begin
            errors++;
            $display("No packet in the reference queue to read at time %0t", $time);
            return;
        end
        n = ref_cnt[0];
        check(WORD_W'(pkt_len), WORD_W'(ref_len[0]), "pkt_len_o before read");
        for (int i = 0; i < n; i++) begin
            order.push_back(i);
        end
        for (int i = n - 1; i > 0; i--) begin
            j        = $urandom_range(i, 0);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        // Valid seen now belongs to the read issued RD_LAT cycles ago
        for (int c = 0; c <= n + RD_LAT; c++) begin
            exp_idx = (c >= RD_LAT && c - RD_LAT < n) ? order[c - RD_LAT] : -1;
            compare_read(exp_idx);
            if (c < n) begin
                rd_en  = 1'b1;
                rd_idx = IDX_W'(order[c]);
            end else begin
                rd_en = 1'b0;
            end
            @(negedge clk);
        end
    endtask

    // Free the drained bank
    task automatic release_packet();
        @(negedge clk);
        check(WORD_W'(pkt_rdy), WORD_W'(full_cnt > 0), "pkt_rdy_o before rd_done");
        rd_done = 1'b1;
        @(negedge clk);
        rd_done = 1'b0;
        if (full_cnt > 0) begin
            for (int i = 0; i < ref_cnt[0]; i++) begin
                void'(ref_words.pop_front());
            end
            void'(ref_cnt.pop_front());
            void'(ref_len.pop_front());
            full_cnt--;
        end
        check_status("after rd_done");
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check(WORD_W'(wr_rdy), WORD_W'(1'b1), "reset: wr_rdy_o");
        check(WORD_W'(pkt_rdy), WORD_W'(1'b0), "reset: pkt_rdy_o");
        check(WORD_W'(rd_vld), WORD_W'(1'b0), "reset: rd_vld_o");
        check(WORD_W'(pkt_len), WORD_W'(0), "reset: pkt_len_o");
    endtask

    task automatic test_single_packet();
        write_packet(8);
        read_packet();
        release_packet();
    endtask

    // Second packet fills the other bank while the first drains
    task automatic test_overlap();
        write_packet(int'($urandom_range(MAX_WORDS, 1)));
        fork
            read_packet();
            write_packet(int'($urandom_range(MAX_WORDS, 1)));
        join
        release_packet();
        read_packet();
        release_packet();
    endtask

    task automatic test_back_pressure();
        write_packet(int'($urandom_range(MAX_WORDS, 1)));
        write_packet(int'($urandom_range(MAX_WORDS, 1)));
        // Both banks full, so this one is lost
        write_packet(4);
        read_packet();
        release_packet();
        write_packet(int'($urandom_range(MAX_WORDS, 1)));
        read_packet();
        release_packet();
        read_packet();
        release_packet();
    endtask

    task automatic test_idle_reads();
        check_status("idle start");
        // Reads and a release with no packet waiting
        for (int c = 0; c < 6; c++) begin
            @(negedge clk);
            compare_read(-1);
            rd_en   = 1'b1;
            rd_idx  = IDX_W'($urandom);
            rd_done = (c == 2);
        end
        @(negedge clk);
        rd_en   = 1'b0;
        rd_done = 1'b0;
        for (int c = 0; c <= RD_LAT; c++) begin
            compare_read(-1);
            @(negedge clk);
        end
        check_status("after idle reads");
        // Packet closed with no words
        write_packet(0);
        read_packet();
        release_packet();
    endtask

    task automatic test_random_packets();
        for (int p = 0; p < 12; p++) begin
            write_packet(int'($urandom_range(MAX_WORDS, 1)));
            // Drain when both banks hold a packet or by chance
            if (full_cnt == 2 || $urandom_range(1, 0) == 1) begin
                read_packet();
                release_packet();
            end
        end
        while (full_cnt > 0) begin
            read_packet();
            release_packet();
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    endtask

    initial begin
        #(WATCHDOG_TIME);
        errors++;
        $display("Watchdog expired at time %0t before the tests completed", $time);
        finish_run();
    end

    initial begin
        void'($urandom(57271));
        errors   = 0;
        full_cnt = 0;
        wr_en    = 1'b0;
        wr_data  = '0;
        byte_inc = '0;
        wr_done  = 1'b0;
        rd_en    = 1'b0;
        rd_idx   = '0;
        rd_done  = 1'b0;
        rst      = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b1;
        test_reset_state();
        test_single_packet();
        test_overlap();
        test_back_pressure();
        test_idle_reads();
        test_random_packets();
        finish_run();
    end

endmodule

`default_nettype wire

// File: all.f
verilog/pkt_buf_pkg.sv
verilog/dp_bram.sv
verilog/pkt_buf.sv
verilog/buf_swap_ctrl.sv
verilog/ping_pong_buf.sv
dv/ping_pong_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ping-pong buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 --Mdir "$OBJ" \
    --top-module ping_pong_tb -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$OBJ/Vping_pong_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
    exit 1
fi

exit 0
